/* Makefile */
SIM_LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_icache -f all.f -Mdir obj_dir -o sim_icache

run: compile
	./obj_dir/sim_icache | tee $(SIM_LOG)
	grep -q "TEST PASSED" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

/* all.f */
verilog/icache_pkg.sv
verilog/icache_data_store.sv
verilog/icache_tag_store.sv
verilog/refill_resp_buffer.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
testbench/tb_icache.sv

/* testbench/icache_stimulus.txt */
// op addr expected_data refill_expected, all hex
// op 0 is a fetch, op 1 is a flush with the other columns unused
0 00000104 A5000104 1
0 00000104 A5000104 0
0 00000106 A5000104 0
0 00000008 A5000008 1
0 00000144 A5000144 1
0 00000104 A5000104 0
0 00000144 A5000144 0
0 00000184 A5000184 1
0 00000144 A5000144 0
0 00000104 A5000104 1
0 00000184 A5000184 0
0 00000144 A5000144 1
0 00000008 A5000008 0
1 00000000 00000000 0
0 00000104 A5000104 1
0 00000008 A5000008 1
0 00000104 A5000104 0
0 0000003C A500003C 1
0 1000003C B500003C 1
0 0000003C A500003C 0
0 1000003C B500003C 0
0 FFFFFFFC 5AFFFFFC 1
0 1000003C B500003C 0
0 0000003F A500003C 1
0 FFFFFFFE 5AFFFFFC 0
1 00000000 00000000 0
1 00000000 00000000 0
0 FFFFFFFC 5AFFFFFC 1

/* testbench/tb_icache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

   // Refill data is the line address XOR this pattern
   localparam logic [31:0] MEM_XOR    = 32'hA500_0000;
   // Four words per stimulus line
   localparam int          MAX_OPS    = 64;
   localparam int          STIM_WORDS = 4 * MAX_OPS;

   logic        clk_i;
   logic        rst_n_i;
   logic        fetch_req_i;
   logic [31:0] fetch_addr_i;
   logic        fetch_gnt_o;
   logic        fetch_rvalid_o;
   logic [31:0] fetch_rdata_o;
   logic        refill_req_o;
   logic        refill_gnt_i;
   logic [31:0] refill_addr_o;
   logic        refill_r_valid_i;
   logic [31:0] refill_r_data_i;
   logic        flush_icache_i;
   logic        cache_is_flushed_o;

   logic [31:0] stim_mem [STIM_WORDS];
   logic [31:0] last_refill_addr;
   int unsigned rng_state     = 32'd60;
   int          cycle_count   = 0;
   int          timeout_limit = 1000;
   int          rvalid_count  = 0;
   int          refill_count  = 0;
   int          accept_count  = 0;

   icache_top DUT (
      .clk_i              ( clk_i              ),
      .rst_n_i            ( rst_n_i            ),
      .fetch_req_i        ( fetch_req_i        ),
      .fetch_addr_i       ( fetch_addr_i       ),
      .fetch_gnt_o        ( fetch_gnt_o        ),
      .fetch_rvalid_o     ( fetch_rvalid_o     ),
      .fetch_rdata_o      ( fetch_rdata_o      ),
      .refill_req_o       ( refill_req_o       ),
      .refill_gnt_i       ( refill_gnt_i       ),
      .refill_addr_o      ( refill_addr_o      ),
      .refill_r_valid_i   ( refill_r_valid_i   ),
      .refill_r_data_i    ( refill_r_data_i    ),
      .flush_icache_i     ( flush_icache_i     ),
      .cache_is_flushed_o ( cache_is_flushed_o )
   );

   // 10 ns clock
   initial
   begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   ///////////////////////////////
   // Helpers
   ///////////////////////////////
   function automatic int unsigned lcg_next();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state >> 16;
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   // Count pulses mid cycle where outputs are settled
   always @(negedge clk_i)
   begin
      if (rst_n_i)
      begin
         if (fetch_rvalid_o)
            rvalid_count++;
         if (refill_req_o && refill_gnt_i)
            refill_count++;
      end
   end

   // Watchdog
   always @(posedge clk_i)
   begin
      cycle_count++;
      if (cycle_count > timeout_limit)
         abort_run($sformatf("timeout after %0d cycles, the DUT stopped answering", cycle_count));
   end

   ///////////////////////////////
   // Program memory model
   ///////////////////////////////
   initial
   begin : memory_model
      int          gnt_delay;
      int          resp_delay;
      logic [31:0] line_addr;
      refill_gnt_i     = 1'b0;
      refill_r_valid_i = 1'b0;
      refill_r_data_i  = '0;
      forever
      begin
         @(posedge clk_i);
         #1;
         if (rst_n_i && refill_req_o)
         begin
            // Grant after 0 to 3 cycles
            gnt_delay = int'(lcg_next() % 32'd4);
            repeat (gnt_delay)
            begin
               @(posedge clk_i);
               #1;
            end
            line_addr        = refill_addr_o;
            last_refill_addr = line_addr;
            refill_gnt_i     = 1'b1;
            @(posedge clk_i);
            #1;
            refill_gnt_i = 1'b0;
            // Response 1 to 4 cycles after the grant cycle
            resp_delay = 1 + int'(lcg_next() % 32'd4);
            repeat (resp_delay - 1)
            begin
               @(posedge clk_i);
               #1;
            end
            refill_r_valid_i = 1'b1;
            refill_r_data_i  = line_addr ^ MEM_XOR;
            @(posedge clk_i);
            #1;
            refill_r_valid_i = 1'b0;
            refill_r_data_i  = '0;
         end
      end
   end

   ///////////////////////////////
   // Operations
   ///////////////////////////////
   task automatic fetch_and_check(input int idx, input logic [31:0] addr,
                                  input logic [31:0] exp_data, input logic exp_refill);
      string       name;
      int          refills_before;
      int          latency;
      int          exp_count;
      logic        granted;
      logic [31:0] got_data;
      name           = $sformatf("op %0d fetch %h", idx, addr);
      refills_before = refill_count;
      fetch_req_i    = 1'b1;
      fetch_addr_i   = addr;
      granted        = 1'b0;
      while (!granted)
      begin
         @(negedge clk_i);
         granted = fetch_gnt_o;
         @(posedge clk_i);
         #1;
      end
      // Drop the address after accept so the DUT must keep its own copy
      fetch_req_i  = 1'b0;
      fetch_addr_i = ~addr;
      accept_count++;
      latency = 0;
      do
      begin
         @(negedge clk_i);
         latency++;
         // Only one fetch may be outstanding
         if (!fetch_rvalid_o)
         begin
            assert (!fetch_gnt_o)
               else abort_run($sformatf("fetch grant high while %s is still outstanding", name));
         end
      end
      while (!fetch_rvalid_o);
      got_data = fetch_rdata_o;
      @(posedge clk_i);
      #1;
      exp_count = exp_refill ? 1 : 0;
      assert (got_data == exp_data)
         else abort_run($sformatf("error: %s data expected %h actual %h", name, exp_data, got_data));
      assert ((refill_count - refills_before) == exp_count)
         else abort_run($sformatf("error: %s refills expected %0d actual %0d",
                                  name, exp_count, refill_count - refills_before));
      if (exp_refill)
      begin
         assert (last_refill_addr == {addr[31:2], 2'b00})
            else abort_run($sformatf("error: %s refill address expected %h actual %h",
                                     name, {addr[31:2], 2'b00}, last_refill_addr));
      end
      else
      begin
         // Hit answers in the cycle right after the accept
         assert (latency == 1)
            else abort_run($sformatf("error: %s hit latency expected 1 actual %0d", name, latency));
      end
      assert (rvalid_count == accept_count)
         else abort_run("number of fetch_rvalid_o pulses differs from the accepted fetches");
   endtask

   task automatic flush_and_check(input int idx);
      string name;
      int    wait_cycles;
      name           = $sformatf("op %0d flush", idx);
      flush_icache_i = 1'b1;
      wait_cycles    = 0;
      do
      begin
         @(negedge clk_i);
         wait_cycles++;
         // Flush wins over a new fetch
         assert (!fetch_gnt_o)
            else abort_run("fetch grant high while a flush is requested");
      end
      while (!cache_is_flushed_o);
      @(posedge clk_i);
      #1;
      flush_icache_i = 1'b0;
      // Done pulse comes one cycle after the flush is taken
      assert (wait_cycles == 2)
         else abort_run($sformatf("error: %s done delay expected 2 actual %0d", name, wait_cycles));
      @(negedge clk_i);
      assert (!cache_is_flushed_o)
         else abort_run("cache_is_flushed_o stayed high for more than one cycle");
      assert (rvalid_count == accept_count)
         else abort_run("fetch_rvalid_o pulsed during a flush");
      @(posedge clk_i);
      #1;
   endtask

   ///////////////////////////////
   // Main sequence
   ///////////////////////////////
   initial
   begin : stimulus
      int n_ops;
      rst_n_i        = 1'b0;
      fetch_req_i    = 1'b0;
      fetch_addr_i   = '0;
      flush_icache_i = 1'b0;
      for (int i = 0; i < STIM_WORDS; i++)
         stim_mem[i] = '1;
      $readmemh("testbench/icache_stimulus.txt", stim_mem);
      // All ones in the op column marks the end of the file
      n_ops = 0;
      while (n_ops < MAX_OPS && stim_mem[4 * n_ops] != '1)
         n_ops++;
      assert (n_ops > 0)
         else abort_run("stimulus file holds no operations");
      timeout_limit = n_ops * 20 + 50;
      repeat (2) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      @(negedge clk_i);
      assert (!fetch_rvalid_o && !refill_req_o && !cache_is_flushed_o)
         else abort_run("outputs not quiet after reset");
      @(posedge clk_i);
      #1;
      for (int k = 0; k < n_ops; k++)
      begin
         if (stim_mem[4 * k] == 32'h1)
            flush_and_check(k);
         else if (stim_mem[4 * k] == 32'h0)
            fetch_and_check(k, stim_mem[4 * k + 1], stim_mem[4 * k + 2], stim_mem[4 * k + 3][0]);
         else
            abort_run($sformatf("unknown operation code on stimulus line %0d", k));
      end
      // Last answer must not repeat
      @(negedge clk_i);
      assert (rvalid_count == accept_count)
         else abort_run("extra fetch_rvalid_o pulse after the last fetch");
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
   import icache_pkg::*;
(
   input  wire logic                                 clk_i,
   input  wire logic                                 rst_n_i,

   // Core fetch port
   input  wire logic                                 fetch_req_i,
   input  wire logic [FETCH_ADDR_WIDTH-1:0]          fetch_addr_i,
   output logic                                      fetch_gnt_o,
   output logic                                      fetch_rvalid_o,
   output logic [FETCH_DATA_WIDTH-1:0]               fetch_rdata_o,

   // Flush request and done pulse
   input  wire logic                                 flush_icache_i,
   output logic                                      cache_is_flushed_o,

   // Refill request towards program memory
   output logic                                      refill_req_o,
   input  wire logic                                 refill_gnt_i,
   output logic [FETCH_ADDR_WIDTH-1:0]               refill_addr_o,

   // Store control
   output logic                                      rd_en_o,
   output logic [SET_ID_WIDTH-1:0]                   set_id_o,
   output logic [NB_WAYS-1:0]                        way_we_o,
   output logic [TAG_WIDTH-1:0]                      tag_wdata_o,
   output logic [FETCH_DATA_WIDTH-1:0]               data_wdata_o,
   output logic                                      flush_all_o,

   // Store read data
   input  wire logic [NB_WAYS-1:0][TAG_WIDTH-1:0]    tag_rdata_i,
   input  wire logic [NB_WAYS-1:0]                   valid_rdata_i,
   input  wire logic [$clog2(NB_WAYS)-1:0]           victim_way_i,
   input  wire logic [NB_WAYS-1:0][FETCH_DATA_WIDTH-1:0] data_rdata_i,

   // Response buffer head
   input  wire logic                                 resp_valid_i,
   input  wire logic [FETCH_DATA_WIDTH-1:0]          resp_data_i,
   output logic                                      resp_pop_o
);

   ctrl_state_e                 state_q;
   ctrl_state_e                 state_d;

   // Address of the fetch in flight
   logic [FETCH_ADDR_WIDTH-1:0] addr_q;

   // Word returned one cycle after the fill
   logic                        refill_done_q;
   logic [FETCH_DATA_WIDTH-1:0] refill_data_q;

   logic [NB_WAYS-1:0]          hit_way;
   logic                        hit;
   logic [FETCH_DATA_WIDTH-1:0] hit_data;

   //////////////////////////////
   // Tag compare
   //////////////////////////////
   always_comb
   begin
      hit_data = '0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         hit_way[w] = valid_rdata_i[w] && (tag_rdata_i[w] == addr_q[TAG_LSB +: TAG_WIDTH]);
         // At most one way matches so an OR is enough
         if (hit_way[w])
            hit_data = hit_data | data_rdata_i[w];
      end
   end

   assign hit = |hit_way;

   // Hit answers straight from LOOKUP, a refill one cycle after the fill
   assign fetch_rvalid_o = ((state_q == LOOKUP) && hit) || refill_done_q;
   assign fetch_rdata_o  = refill_done_q ? refill_data_q : hit_data;

   // Line aligned refill address
   assign refill_addr_o  = {addr_q[FETCH_ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

   // Fill payload
   assign tag_wdata_o    = addr_q[TAG_LSB +: TAG_WIDTH];
   assign data_wdata_o   = resp_data_i;

   //////////////////////////////
   // Next state
   //////////////////////////////
   always_comb
   begin
      state_d            = state_q;
      fetch_gnt_o        = 1'b0;
      rd_en_o            = 1'b0;
      set_id_o           = addr_q[SET_ID_MSB:SET_ID_LSB];
      way_we_o           = '0;
      flush_all_o        = 1'b0;
      resp_pop_o         = 1'b0;
      refill_req_o       = 1'b0;
      cache_is_flushed_o = 1'b0;

      case (state_q)
         IDLE:
         begin
            // Flush wins over a new fetch
            if (flush_icache_i)
            begin
               flush_all_o = 1'b1;
               state_d     = FLUSH;
            end
            else
            begin
               fetch_gnt_o = 1'b1;
               set_id_o    = fetch_addr_i[SET_ID_MSB:SET_ID_LSB];
               if (fetch_req_i)
               begin
                  rd_en_o = 1'b1;
                  state_d = LOOKUP;
               end
            end
         end

         LOOKUP:
         begin
            state_d = hit ? IDLE : REFILL_REQ;
         end

         REFILL_REQ:
         begin
            refill_req_o = 1'b1;
            if (refill_gnt_i)
               state_d = REFILL_WAIT;
         end

         REFILL_WAIT:
         begin
            // Fill the victim way as the word leaves the buffer
            if (resp_valid_i)
            begin
               resp_pop_o = 1'b1;
               way_we_o   = NB_WAYS'(1) << victim_way_i;
               state_d    = IDLE;
            end
         end

         FLUSH:
         begin
            // Valid bits went clear at the last edge
            cache_is_flushed_o = 1'b1;
            state_d            = IDLE;
         end

         default:
         begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         state_q       <= IDLE;
         refill_done_q <= 1'b0;
      end
      else
      begin
         state_q       <= state_d;
         refill_done_q <= resp_pop_o;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (fetch_req_i && fetch_gnt_o)
         addr_q <= fetch_addr_i;
      if (resp_pop_o)
         refill_data_q <= resp_data_i;
   end

   //////////////////////////////
   // Checks
   //////////////////////////////
   // Fills only go to the victim, so a line never sits in both ways
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (state_q == LOOKUP) |-> $onehot0(hit_way));

   // Memory sees a stable request until it grants
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (refill_req_o && !refill_gnt_i) |=> (refill_req_o && $stable(refill_addr_o)));

endmodule

`default_nettype wire

/* verilog/icache_data_store.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_data_store
   import icache_pkg::*;
(
   input  wire logic                             clk_i,
   input  wire logic                             rd_en_i,
   input  wire logic [SET_ID_WIDTH-1:0]          set_id_i,
   input  wire logic [NB_WAYS-1:0]               way_we_i,
   input  wire logic [FETCH_DATA_WIDTH-1:0]      data_wdata_i,
   output logic [NB_WAYS-1:0][FETCH_DATA_WIDTH-1:0] data_rdata_o
);

   // One instruction word per line
   logic [FETCH_DATA_WIDTH-1:0] data_mem_q [NB_WAYS][NB_SETS];

   //////////////////////////////
   // Write and registered read
   //////////////////////////////
   always_ff @(posedge clk_i)
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (way_we_i[w])
            data_mem_q[w][set_id_i] <= data_wdata_i;
         // Both ways read out, the controller picks the hit
         if (rd_en_i)
            data_rdata_o[w] <= data_mem_q[w][set_id_i];
      end
   end

endmodule

`default_nettype wire

/* verilog/icache_pkg.sv */
`default_nettype none

package icache_pkg;

   ///////////////////////////////
   // Fetch and refill word sizes
   ///////////////////////////////
   localparam int FETCH_ADDR_WIDTH = 32;
   localparam int FETCH_DATA_WIDTH = 32;

   // Two ways of sixteen one-word lines
   localparam int NB_WAYS          = 2;
   localparam int NB_SETS          = 16;
   localparam int SET_ID_WIDTH     = 4;

   ///////////////////////////////
   // Address split
   ///////////////////////////////
   // Byte offset inside the word, never stored
   localparam int OFFSET_WIDTH     = 2;
   localparam int SET_ID_LSB       = 2;
   localparam int SET_ID_MSB       = 5;
   // Everything above the set index goes into the tag
   localparam int TAG_LSB          = 6;
   localparam int TAG_WIDTH        = 26;

   // Refill response buffer geometry
   localparam int RESP_BUF_DEPTH   = 2;
   localparam int RESP_PTR_WIDTH   = 1;
   localparam int RESP_CNT_WIDTH   = 2;

   // Controller states
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      REFILL_REQ,
      REFILL_WAIT,
      FLUSH
   } ctrl_state_e;

endpackage

`default_nettype wire

/* verilog/icache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store
   import icache_pkg::*;
(
   input  wire logic                        clk_i,
   input  wire logic                        rst_n_i,
   input  wire logic                        rd_en_i,
   input  wire logic [SET_ID_WIDTH-1:0]     set_id_i,
   input  wire logic [NB_WAYS-1:0]          way_we_i,
   input  wire logic [TAG_WIDTH-1:0]        tag_wdata_i,
   input  wire logic                        flush_all_i,
   output logic [NB_WAYS-1:0][TAG_WIDTH-1:0] tag_rdata_o,
   output logic [NB_WAYS-1:0]               valid_rdata_o,
   output logic [$clog2(NB_WAYS)-1:0]       victim_way_o
);

   logic [TAG_WIDTH-1:0]                      tag_mem_q [NB_WAYS][NB_SETS];
   logic [NB_WAYS-1:0][NB_SETS-1:0]           valid_q;
   // Round-robin pointer, one per set
   logic [NB_SETS-1:0][$clog2(NB_WAYS)-1:0]   victim_q;

   //////////////////////////////
   // Valid bits and victim pointers
   //////////////////////////////
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         valid_q  <= '0;
         victim_q <= '0;
      end
      else if (flush_all_i)
         valid_q <= '0;
      else if (|way_we_i)
      begin
         for (int w = 0; w < NB_WAYS; w++)
            if (way_we_i[w])
               valid_q[w][set_id_i] <= 1'b1;
         // Next fill of this set goes to the other way
         victim_q[set_id_i] <= victim_q[set_id_i] + 1'b1;
      end
   end

   // Tag array
   always_ff @(posedge clk_i)
   begin
      for (int w = 0; w < NB_WAYS; w++)
         if (way_we_i[w])
            tag_mem_q[w][set_id_i] <= tag_wdata_i;
   end

   // Registered read of all ways at once
   always_ff @(posedge clk_i)
   begin
      if (rd_en_i)
      begin
         for (int w = 0; w < NB_WAYS; w++)
         begin
            tag_rdata_o[w]   <= tag_mem_q[w][set_id_i];
            valid_rdata_o[w] <= valid_q[w][set_id_i];
         end
         victim_way_o <= victim_q[set_id_i];
      end
   end

   // A fill writes a single way
   assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(way_we_i));

endmodule

`default_nettype wire

/* verilog/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top
   import icache_pkg::*;
(
   input  wire logic                        clk_i,
   input  wire logic                        rst_n_i,

   // Core fetch port
   input  wire logic                        fetch_req_i,
   input  wire logic [FETCH_ADDR_WIDTH-1:0] fetch_addr_i,
   output logic                             fetch_gnt_o,
   output logic                             fetch_rvalid_o,
   output logic [FETCH_DATA_WIDTH-1:0]      fetch_rdata_o,

   // Program memory refill port
   output logic                             refill_req_o,
   input  wire logic                        refill_gnt_i,
   output logic [FETCH_ADDR_WIDTH-1:0]      refill_addr_o,
   input  wire logic                        refill_r_valid_i,
   input  wire logic [FETCH_DATA_WIDTH-1:0] refill_r_data_i,

   // Whole cache flush
   input  wire logic                        flush_icache_i,
   output logic                             cache_is_flushed_o
);

   // Controller to stores
   logic                                    rd_en;
   logic [SET_ID_WIDTH-1:0]                 set_id;
   logic [NB_WAYS-1:0]                      way_we;
   logic [TAG_WIDTH-1:0]                    tag_wdata;
   logic [FETCH_DATA_WIDTH-1:0]             data_wdata;
   logic                                    flush_all;

   // Stores back to controller
   logic [NB_WAYS-1:0][TAG_WIDTH-1:0]       tag_rdata;
   logic [NB_WAYS-1:0]                      valid_rdata;
   logic [$clog2(NB_WAYS)-1:0]              victim_way;
   logic [NB_WAYS-1:0][FETCH_DATA_WIDTH-1:0] data_rdata;

   // Response buffer head
   logic                                    resp_valid;
   logic [FETCH_DATA_WIDTH-1:0]             resp_data;
   logic                                    resp_pop;

   //////////////////////////////
   // Controller
   //////////////////////////////
   icache_ctrl i_icache_ctrl (
      .clk_i              ( clk_i              ),
      .rst_n_i            ( rst_n_i            ),
      .fetch_req_i        ( fetch_req_i        ),
      .fetch_addr_i       ( fetch_addr_i       ),
      .fetch_gnt_o        ( fetch_gnt_o        ),
      .fetch_rvalid_o     ( fetch_rvalid_o     ),
      .fetch_rdata_o      ( fetch_rdata_o      ),
      .flush_icache_i     ( flush_icache_i     ),
      .cache_is_flushed_o ( cache_is_flushed_o ),
      .refill_req_o       ( refill_req_o       ),
      .refill_gnt_i       ( refill_gnt_i       ),
      .refill_addr_o      ( refill_addr_o      ),
      .rd_en_o            ( rd_en              ),
      .set_id_o           ( set_id             ),
      .way_we_o           ( way_we             ),
      .tag_wdata_o        ( tag_wdata          ),
      .data_wdata_o       ( data_wdata         ),
      .flush_all_o        ( flush_all          ),
      .tag_rdata_i        ( tag_rdata          ),
      .valid_rdata_i      ( valid_rdata        ),
      .victim_way_i       ( victim_way         ),
      .data_rdata_i       ( data_rdata         ),
      .resp_valid_i       ( resp_valid         ),
      .resp_data_i        ( resp_data          ),
      .resp_pop_o         ( resp_pop           )
   );

   //////////////////////////////
   // Tag and data stores
   //////////////////////////////
   icache_tag_store i_icache_tag_store (
      .clk_i         ( clk_i       ),
      .rst_n_i       ( rst_n_i     ),
      .rd_en_i       ( rd_en       ),
      .set_id_i      ( set_id      ),
      .way_we_i      ( way_we      ),
      .tag_wdata_i   ( tag_wdata   ),
      .flush_all_i   ( flush_all   ),
      .tag_rdata_o   ( tag_rdata   ),
      .valid_rdata_o ( valid_rdata ),
      .victim_way_o  ( victim_way  )
   );

   icache_data_store i_icache_data_store (
      .clk_i        ( clk_i      ),
      .rd_en_i      ( rd_en      ),
      .set_id_i     ( set_id     ),
      .way_we_i     ( way_we     ),
      .data_wdata_i ( data_wdata ),
      .data_rdata_o ( data_rdata )
   );

   // Memory responses land here before the controller sees them
   refill_resp_buffer i_refill_resp_buffer (
      .clk_i        ( clk_i            ),
      .rst_n_i      ( rst_n_i          ),
      .push_valid_i ( refill_r_valid_i ),
      .push_data_i  ( refill_r_data_i  ),
      .resp_pop_i   ( resp_pop         ),
      .resp_valid_o ( resp_valid       ),
      .resp_data_o  ( resp_data        )
   );

endmodule

`default_nettype wire

/* verilog/refill_resp_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module refill_resp_buffer
   import icache_pkg::*;
(
   input  wire logic                        clk_i,
   input  wire logic                        rst_n_i,

   // Producer side, program memory response
   input  wire logic                        push_valid_i,
   input  wire logic [FETCH_DATA_WIDTH-1:0] push_data_i,

   // Consumer side, cache controller
   input  wire logic                        resp_pop_i,
   output logic                             resp_valid_o,
   output logic [FETCH_DATA_WIDTH-1:0]      resp_data_o
);

   logic [FETCH_DATA_WIDTH-1:0] buf_mem_q [RESP_BUF_DEPTH];
   logic [RESP_PTR_WIDTH-1:0]   head_q;
   logic [RESP_PTR_WIDTH-1:0]   tail_q;
   logic [RESP_CNT_WIDTH-1:0]   count_q;
   logic                        full;

   assign full         = (count_q == RESP_CNT_WIDTH'(RESP_BUF_DEPTH));
   assign resp_valid_o = (count_q != '0);
   assign resp_data_o  = buf_mem_q[head_q];

   //////////////////////////////
   // Pointers and occupancy
   //////////////////////////////
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
      end
      else
      begin
         // Power of two depth so pointers wrap on their own
         if (push_valid_i)
            tail_q <= tail_q + 1'b1;
         if (resp_pop_i)
            head_q <= head_q + 1'b1;
         case ({push_valid_i, resp_pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Entry storage
   always_ff @(posedge clk_i)
   begin
      if (push_valid_i)
         buf_mem_q[tail_q] <= push_data_i;
   end

   // Memory has no back-pressure so it must never find the buffer full
   assert property (@(posedge clk_i) disable iff (!rst_n_i) !(push_valid_i && full));

   // Controller only pops a valid head
   assert property (@(posedge clk_i) disable iff (!rst_n_i) resp_pop_i |-> resp_valid_o);

endmodule

`default_nettype wire
